//--- src/matrix_pkg.sv
package matrix_pkg;

    // count width and range
    localparam int DIGIT_W = 3;
    localparam logic [DIGIT_W-1:0] MAX_COUNT = DIGIT_W'(5);

    // timing, in clk cycles
    localparam int SEC_CLKS  = 64;   // one countdown step
    localparam int SEC_W     = $clog2(SEC_CLKS);
    localparam int SCAN_CLKS = 4;    // time each row stays lit
    localparam int SCAN_W    = $clog2(SCAN_CLKS);

    // panel geometry
    localparam int ROWS  = 8;
    localparam int ROW_W = $clog2(ROWS);

    // colour thresholds: red at RED_MIN and up, green below YELLOW_MIN
    localparam logic [DIGIT_W-1:0] YELLOW_MIN = DIGIT_W'(2);
    localparam logic [DIGIT_W-1:0] RED_MIN    = DIGIT_W'(4);

    // column masks per digit, row 0 first
    localparam logic [0:MAX_COUNT][0:ROWS-1][ROWS-1:0] GLYPH = '{
        '{8'h00, 8'h3C, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h3C},  // 0
        '{8'h00, 8'h18, 8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h7E},  // 1
        '{8'h3C, 8'h66, 8'h00, 8'h06, 8'h0C, 8'h30, 8'h60, 8'h7E},  // 2
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},  // 3
        '{8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00},  // 4
        '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00}   // 5
    };

endpackage

//--- src/countdown_ctrl.sv
`timescale 1ns/1ns

module countdown_ctrl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load_valid,
    input  logic [matrix_pkg::DIGIT_W-1:0]   load_count,
    output logic                             load_ready,
    output logic [matrix_pkg::DIGIT_W-1:0]   count,
    output logic                             done
);

    logic                           running;
    logic [matrix_pkg::SEC_W-1:0]   sec_cnt;
    logic [matrix_pkg::DIGIT_W-1:0] load_clamped;
    logic                           accept;
    logic                           sec_tick;
    logic                           last_step;

    // anything above the top digit shows as the top digit
    assign load_clamped = (load_count > matrix_pkg::MAX_COUNT) ? matrix_pkg::MAX_COUNT
                                                               : load_count;

    assign load_ready = ~running;  // idle means ready
    assign accept     = load_valid & load_ready;

    assign sec_tick  = running & (sec_cnt == matrix_pkg::SEC_CLKS - 1);
    assign last_step = sec_tick & (count == 1);

    // one-second prescaler, restarted by every accepted load
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            sec_cnt <= '0;
        else if (accept || sec_tick)
            sec_cnt <= '0;
        else if (running)
            sec_cnt <= sec_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            count <= '0;
        else if (accept)
            count <= load_clamped;
        else if (sec_tick)
            count <= count - 1'b1;
    end

    // a zero load leaves the controller idle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            running <= 1'b0;
        else if (accept)
            running <= (load_clamped != '0);
        else if (last_step)
            running <= 1'b0;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            done <= 1'b0;
        else
            done <= last_step;  // single cycle, same edge as ready rising
    end

endmodule

//--- src/dot_matrix_scan.sv
`timescale 1ns/1ns

module dot_matrix_scan (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [matrix_pkg::DIGIT_W-1:0]   count,
    output logic [matrix_pkg::ROWS-1:0]      row,
    output logic [matrix_pkg::ROWS-1:0]      colr,
    output logic [matrix_pkg::ROWS-1:0]      colg
);

    logic [matrix_pkg::DIGIT_W-1:0] digit_q;
    logic [matrix_pkg::SCAN_W-1:0]  scan_cnt;
    logic [matrix_pkg::ROW_W-1:0]   row_cnt;
    logic                           row_step;
    logic [matrix_pkg::ROWS-1:0]    row_sel;
    logic [matrix_pkg::ROWS-1:0]    mask;
    logic                           red_on;
    logic                           green_on;

    // sampled digit, the pattern is built from this copy
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            digit_q <= '0;
        else
            digit_q <= count;
    end

    assign row_step = (scan_cnt == matrix_pkg::SCAN_CLKS - 1);

    // scan prescaler
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            scan_cnt <= '0;
        else if (row_step)
            scan_cnt <= '0;
        else
            scan_cnt <= scan_cnt + 1'b1;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            row_cnt <= '0;
        else if (row_step)
        begin
            if (row_cnt == matrix_pkg::ROWS - 1)
                row_cnt <= '0;  // wrap after last row
            else
                row_cnt <= row_cnt + 1'b1;
        end
    end

    // one active-low row at a time
    always_comb
    begin
        case (row_cnt)
            3'd0:    row_sel = 8'b1111_1110;
            3'd1:    row_sel = 8'b1111_1101;
            3'd2:    row_sel = 8'b1111_1011;
            3'd3:    row_sel = 8'b1111_0111;
            3'd4:    row_sel = 8'b1110_1111;
            3'd5:    row_sel = 8'b1101_1111;
            3'd6:    row_sel = 8'b1011_1111;
            3'd7:    row_sel = 8'b0111_1111;
            default: row_sel = 8'b1111_1111;
        endcase
    end

    // glyph lookup, blank for codes past the table
    always_comb
    begin
        if (digit_q <= matrix_pkg::MAX_COUNT)
            mask = matrix_pkg::GLYPH[digit_q][row_cnt];
        else
            mask = '0;
    end

    // both on gives yellow
    assign red_on   = (digit_q >= matrix_pkg::YELLOW_MIN);
    assign green_on = (digit_q < matrix_pkg::RED_MIN);

    // row and columns leave on the same edge
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= '1;  // nothing lit
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= row_sel;
            colr <= red_on ? mask : '0;
            colg <= green_on ? mask : '0;
        end
    end

endmodule

//--- src/countdown_display_top.sv
`timescale 1ns/1ns

module countdown_display_top (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             load_valid,
    input  logic [matrix_pkg::DIGIT_W-1:0]   load_count,
    output logic                             load_ready,
    output logic [matrix_pkg::DIGIT_W-1:0]   count,
    output logic                             done,
    output logic [matrix_pkg::ROWS-1:0]      row,
    output logic [matrix_pkg::ROWS-1:0]      colr,
    output logic [matrix_pkg::ROWS-1:0]      colg
);

    // load handshake, count and done pulse
    countdown_ctrl countdown_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .load_valid (load_valid),
        .load_count (load_count),
        .load_ready (load_ready),
        .count      (count),
        .done       (done)
    );

    // count also feeds the panel
    dot_matrix_scan dot_matrix_scan_i (
        .clk   (clk),
        .rst   (rst),
        .count (count),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

endmodule

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk
);

    // 40 ns period
    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

endmodule

//--- dv/countdown_display_properties.sv
`timescale 1ns/1ns

module countdown_display_properties (
    input logic                           clk,
    input logic                           rst,
    input logic                           load_ready,
    input logic [matrix_pkg::DIGIT_W-1:0] count,
    input logic                           done,
    input logic [matrix_pkg::ROWS-1:0]    row,
    input logic [matrix_pkg::ROWS-1:0]    colr,
    input logic [matrix_pkg::ROWS-1:0]    colg
);

    int unsigned violations = 0;

    // a single active-low row, or none
    row_single: assert property (@(posedge clk) disable iff (rst)
        ($onehot(~row) || (row == '1)))
    else
    begin
        violations++;
        $error("row drives more than one line low: %b", row);
    end

    done_single: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else
    begin
        violations++;
        $error("done stayed high for two cycles");
    end

    ready_idle: assert property (@(posedge clk) disable iff (rst)
        (count != '0) |-> !load_ready)
    else
    begin
        violations++;
        $error("load_ready high while count is %h", count);
    end

    // yellow means both colours carry the same mask
    colour_same: assert property (@(posedge clk) disable iff (rst)
        ((colr != '0) && (colg != '0)) |-> (colr == colg))
    else
    begin
        violations++;
        $error("colr %h and colg %h lit with different masks", colr, colg);
    end

endmodule

//--- dv/countdown_display_tb.sv
`timescale 1ns/1ns

module countdown_display_tb;

    logic                           clk;
    logic                           rst;
    logic                           load_valid;
    logic [matrix_pkg::DIGIT_W-1:0] load_count;
    logic                           load_ready;
    logic [matrix_pkg::DIGIT_W-1:0] count;
    logic                           done;
    logic [matrix_pkg::ROWS-1:0]    row;
    logic [matrix_pkg::ROWS-1:0]    colr;
    logic [matrix_pkg::ROWS-1:0]    colg;

    int          vals[$];  // six fields per case
    int unsigned cycles = 0;
    int unsigned limit = 0;

    tb_clock_gen clock_gen_i (.clk(clk));

    countdown_display_top countdown_display_top_i (
        .clk        (clk),
        .rst        (rst),
        .load_valid (load_valid),
        .load_count (load_count),
        .load_ready (load_ready),
        .count      (count),
        .done       (done),
        .row        (row),
        .colr       (colr),
        .colg       (colg)
    );

    bind countdown_display_top countdown_display_properties countdown_display_properties_i (
        .clk        (clk),
        .rst        (rst),
        .load_ready (load_ready),
        .count      (count),
        .done       (done),
        .row        (row),
        .colr       (colr),
        .colg       (colg)
    );

    task report_failure;
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic fail_with(input string msg);
        $display("%s", msg);
        report_failure();
    endtask

    task automatic check_count(input string name, input logic [matrix_pkg::DIGIT_W-1:0] exp_val,
                               input logic [matrix_pkg::DIGIT_W-1:0] act_val);
        if (act_val !== exp_val)
            fail_with($sformatf("Mismatch %s: expected %h, actual %h", name, exp_val, act_val));
    endtask

    task automatic check_byte(input string name, input logic [matrix_pkg::ROWS-1:0] exp_val,
                              input logic [matrix_pkg::ROWS-1:0] act_val);
        if (act_val !== exp_val)
            fail_with($sformatf("Mismatch %s: expected %h, actual %h", name, exp_val, act_val));
    endtask

    task automatic check_flag(input string name, input logic exp_val, input logic act_val);
        if (act_val !== exp_val)
            fail_with($sformatf("Mismatch %s: expected %h, actual %h", name, exp_val, act_val));
    endtask

    // returns just after the accepting edge
    task automatic accept_load(input logic [matrix_pkg::DIGIT_W-1:0] value);
        @(posedge clk);
        load_valid <= 1'b1;
        load_count <= value;
        @(negedge clk);
        while (load_ready !== 1'b1)
            @(negedge clk);
        @(posedge clk);
        load_valid <= 1'b0;
    endtask

    // follows a run edge by edge, hold = -1 keeps load_valid up to the end
    task automatic follow_run(input int secs, input int hold,
                              input logic [matrix_pkg::DIGIT_W-1:0] hold_val);
        int last;
        int j;
        int remaining;
        last = secs * matrix_pkg::SEC_CLKS;
        if (hold != 0)
        begin
            load_valid <= 1'b1;
            load_count <= hold_val;
        end
        for (j = 0; j <= last; j++)
        begin
            if (j > 0)
            begin
                @(posedge clk);
                if (j == hold)
                    load_valid <= 1'b0;
            end
            @(negedge clk);
            remaining = secs - j / matrix_pkg::SEC_CLKS;
            check_count("count", remaining[matrix_pkg::DIGIT_W-1:0], count);
            check_flag("load_ready", j == last, load_ready);
            if (j == last && secs != 0 && done !== 1'b1)
                fail_with($sformatf("done pulse missing at the end of a %0d second run", secs));
            if ((j != last || secs == 0) && done !== 1'b0)
                fail_with($sformatf("done high %0d cycles into a %0d second run", j, secs));
        end
    endtask

    task automatic check_glyph(input int load, input int ridx, input int exp_row,
                               input int exp_r, input int exp_g);
        int waited;
        accept_load(load[matrix_pkg::DIGIT_W-1:0]);
        repeat (2) @(posedge clk);  // digit register, then output register
        waited = 0;
        @(negedge clk);
        while (row !== exp_row[matrix_pkg::ROWS-1:0])
        begin
            waited++;
            if (waited > 2 * matrix_pkg::ROWS * matrix_pkg::SCAN_CLKS)
                fail_with($sformatf("row pattern %h never appeared after loading %0d",
                                    exp_row, load));
            @(negedge clk);
        end
        check_byte($sformatf("colr in row %0d", ridx), exp_r[matrix_pkg::ROWS-1:0], colr);
        check_byte($sformatf("colg in row %0d", ridx), exp_g[matrix_pkg::ROWS-1:0], colg);
    endtask

    task automatic check_timing(input int load, input int secs);
        int hold;
        hold = 0;
        if (secs > 0)
            hold = $urandom_range(secs * matrix_pkg::SEC_CLKS - 1, 1);  // ignored load
        accept_load(load[matrix_pkg::DIGIT_W-1:0]);
        follow_run(secs, hold, matrix_pkg::DIGIT_W'($urandom_range(7, 0)));
    endtask

    task automatic check_backpressure(input int load_a, input int secs_a,
                                      input int load_b, input int secs_b);
        accept_load(load_a[matrix_pkg::DIGIT_W-1:0]);
        follow_run(secs_a, -1, load_b[matrix_pkg::DIGIT_W-1:0]);
        @(posedge clk);  // ready is high, held load goes in
        load_valid <= 1'b0;
        follow_run(secs_b, 0, '0);
    endtask

    always @(negedge clk)
    begin
        cycles++;
        if (limit != 0 && cycles >= limit)
            fail_with($sformatf("timeout after %0d cycles, the DUT stopped making progress",
                                cycles));
        if (countdown_display_top_i.countdown_display_properties_i.violations != 0)
            fail_with("a bound assertion on the DUT fired");
    end

    initial
    begin
        int    fd;
        string line;
        int    f[6];
        int    n;
        int    k;
        int    ncases;
        rst        = 1'b1;
        load_valid = 1'b0;
        load_count = '0;
        void'($urandom(32'h9713_6432));

        fd = $fopen("dv/countdown_display_cases.txt", "r");
        if (fd == 0)
            fail_with("cannot open dv/countdown_display_cases.txt");
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5]);
            if (n >= 3)
                for (k = 0; k < 6; k++)
                    vals.push_back((n > k) ? f[k] : 0);
        end
        $fclose(fd);
        ncases = vals.size() / 6;
        limit = ncases * (6 * matrix_pkg::SEC_CLKS + 100);

        repeat (10) @(posedge clk);
        rst <= 1'b0;

        // idle state, digit 0 shown in green only
        @(negedge clk);
        check_flag("load_ready", 1'b1, load_ready);
        check_flag("done", 1'b0, done);
        check_count("count", '0, count);
        check_byte("row", '1, row);
        check_byte("colr", '0, colr);
        check_byte("colg", '0, colg);
        repeat (matrix_pkg::ROWS * matrix_pkg::SCAN_CLKS + 2)
        begin
            @(negedge clk);
            check_byte("colr", '0, colr);
        end

        for (k = 0; k < ncases; k++)
        begin
            repeat ($urandom_range(7, 0)) @(posedge clk);
            case (vals[6*k])
                0: check_glyph(vals[6*k+1], vals[6*k+2], vals[6*k+3], vals[6*k+4], vals[6*k+5]);
                1: check_timing(vals[6*k+1], vals[6*k+2]);
                2: check_backpressure(vals[6*k+1], vals[6*k+2], vals[6*k+3], vals[6*k+4]);
                default: fail_with($sformatf("unknown case kind %0d in the cases file", vals[6*k]));
            endcase
        end

        if (countdown_display_top_i.countdown_display_properties_i.violations == 0)
        begin
            $display("Verification passed");
            $finish;
        end
        else
            fail_with("a bound assertion on the DUT fired");
    end

endmodule

//--- dv/countdown_display_cases.txt
# glyph: 0 load row_index row colr colg, timing: 1 load seconds (all hex)
# back-pressure: 2 load_a seconds_a held_load_b seconds_b
0 0 0 FE 00 00
0 0 1 FD 00 3C
0 0 2 FB 00 42
0 0 3 F7 00 42
0 0 4 EF 00 42
0 0 5 DF 00 42
0 0 6 BF 00 42
0 0 7 7F 00 3C
0 1 0 FE 00 00
0 1 1 FD 00 18
0 1 2 FB 00 18
0 1 3 F7 00 38
0 1 4 EF 00 18
0 1 5 DF 00 18
0 1 6 BF 00 18
0 1 7 7F 00 7E
0 2 0 FE 3C 3C
0 2 1 FD 66 66
0 2 2 FB 00 00
0 2 3 F7 06 06
0 2 4 EF 0C 0C
0 2 5 DF 30 30
0 2 6 BF 60 60
0 2 7 7F 7E 7E
0 3 0 FE 3C 3C
0 3 1 FD 66 66
0 3 2 FB 06 06
0 3 3 F7 1C 1C
0 3 4 EF 06 06
0 3 5 DF 66 66
0 3 6 BF 3C 3C
0 3 7 7F 00 00
0 4 0 FE 0C 00
0 4 1 FD 1C 00
0 4 2 FB 2C 00
0 4 3 F7 4C 00
0 4 4 EF 7E 00
0 4 5 DF 0C 00
0 4 6 BF 0C 00
0 4 7 7F 00 00
0 5 0 FE 7E 00
0 5 1 FD 60 00
0 7 2 FB 7C 00
0 5 3 F7 06 00
0 6 4 EF 06 00
0 5 5 DF 66 00
0 5 6 BF 3C 00
0 5 7 7F 00 00
1 1 1
1 2 2
1 3 3
1 4 4
1 5 5
1 6 5
1 7 5
1 0 0
2 3 3 7 5
2 1 1 2 2

//--- vlog.f
src/matrix_pkg.sv
src/countdown_ctrl.sv
src/dot_matrix_scan.sv
src/countdown_display_top.sv
dv/tb_clock_gen.sv
dv/countdown_display_properties.sv
dv/countdown_display_tb.sv
